/* rp_analog_top.f */
source/rp_pkg.sv
source/reset_ctrl.sv
source/adc_frontend.sv
source/dac_mixer.sv
source/exp_pin_mux.sv
source/rp_analog_top.sv
testbench/tb_rp_checker.sv
testbench/tb_rp_analog_top.sv

/* source/adc_frontend.sv */
module adc_frontend import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  logic      digital_loop_i,  // DAC values replace ADC
  input  raw_pair_t adc_raw_i,       // Straight from the converter
  input  smp_pair_t loop_i,          // Clamped mixer sums
  output adc_pair_t adc_o
);

adc_pair_t adc_d;  // Next sample pair

//////////////////////////////////////////////////////////////////////
// Code conversion
//////////////////////////////////////////////////////////////////////

// Negative slope to two's complement, MSB kept
function automatic adc_smp_t adc_conv(
  input adc_raw_t raw,
  input logic     loop_en,
  input dac_smp_t loop
);
  if (loop_en) begin
    return {{(ADC_W-DAC_W){1'b0}}, loop};  // Zero extended, not sign extended
  end
  return {raw[ADC_W-1], ~raw[ADC_W-2:0]};
endfunction

always_comb begin
  adc_d.a = adc_conv(adc_raw_i.a, digital_loop_i, loop_i.a);  // CH 1
  adc_d.b = adc_conv(adc_raw_i.b, digital_loop_i, loop_i.b);  // CH 2
end

//////////////////////////////////////////////////////////////////////
// Output register
//////////////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    adc_o <= '0;
  end else begin
    adc_o <= adc_d;
  end
end

endmodule : adc_frontend

/* source/dac_mixer.sv */
module dac_mixer import rp_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  smp_pair_t gen_i,   // Generator samples
  input  smp_pair_t ctl_i,   // Controller samples
  output smp_pair_t loop_o,  // Clamped sums, combinational
  output dac_pair_t dac_o    // Negative-slope codes
);

logic signed [SUM_W-1:0] sum_a;  // CH 1 raw sum
logic signed [SUM_W-1:0] sum_b;  // CH 2 raw sum

//////////////////////////////////////////////////////////////////////
// Sum and saturation
//////////////////////////////////////////////////////////////////////

// Top two bits differ on overflow, clamp to the extreme of that sign
function automatic dac_smp_t sat(input logic signed [SUM_W-1:0] sum);
  if (sum[SUM_W-1] ^ sum[SUM_W-2]) begin
    return {sum[SUM_W-1], {(DAC_W-1){~sum[SUM_W-1]}}};
  end
  return sum[DAC_W-1:0];
endfunction

// Back to negative slope for the converter
function automatic dac_code_t neg_slope(input dac_smp_t smp);
  return {smp[DAC_W-1], ~smp[DAC_W-2:0]};
endfunction

assign sum_a = gen_i.a + ctl_i.a;  // Sign extended to SUM_W
assign sum_b = gen_i.b + ctl_i.b;

always_comb begin
  loop_o.a = sat(sum_a);
  loop_o.b = sat(sum_b);
end

//////////////////////////////////////////////////////////////////////
// Output register
//////////////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    dac_o <= '0;  // Nothing driven in reset
  end else begin
    dac_o.a <= neg_slope(loop_o.a);
    dac_o.b <= neg_slope(loop_o.b);
  end
end

// Code MSB is the clamped sign, which must match the sum one edge earlier
a_sign_a: assert property (@(posedge adc_clk)
  rst_n_i && $past(rst_n_i) |-> dac_o.a[DAC_W-1] == $past(sum_a[SUM_W-1]))
  else $error("CH 1 clamped sign differs from sum");

a_sign_b: assert property (@(posedge adc_clk)
  rst_n_i && $past(rst_n_i) |-> dac_o.b[DAC_W-1] == $past(sum_b[SUM_W-1]))
  else $error("CH 2 clamped sign differs from sum");

endmodule : dac_mixer

/* source/exp_pin_mux.sv */
module exp_pin_mux import rp_pkg::*; (
  input  logic               adc_clk,
  input  logic               rst_n_i,
  input  daisy_mode_t        mode_i,
  input  exp_vec_t           exp_p_i,       // P row inputs, p[0] is ext trigger
  input  exp_vec_t           exp_n_dat_i,   // Housekeeping data
  input  exp_vec_t           exp_n_dir_i,   // Housekeeping direction, 1 output
  input  logic [DAISY_W-1:0] daisy_dat_i,   // Received daisy word
  input  logic               gen_trig_i,
  input  logic               scope_trig_i,
  output exp_vec_t           exp_n_o,
  output exp_vec_t           exp_n_oe_o,
  output logic               trig_ext_o
);

logic     daisy_trig;
logic     trig_ext;
logic     trig_sel;   // Trigger for n[0]
exp_vec_t n_alt;      // Alternate function enable
exp_vec_t n_alt_dat;
exp_vec_t n_dat;
exp_vec_t n_dir;

//////////////////////////////////////////////////////////////////////
// Triggers
//////////////////////////////////////////////////////////////////////

assign daisy_trig = |daisy_dat_i;  // Any bit set
assign trig_ext   = exp_p_i[0] & ~(mode_i.sync_mode & daisy_trig);
assign trig_sel   = mode_i.trig_src_gen ? gen_trig_i : scope_trig_i;

//////////////////////////////////////////////////////////////////////
// Pin override
//////////////////////////////////////////////////////////////////////

// Only n[0] has an alternate function
assign n_alt     = {{(EXP_W-1){1'b0}}, mode_i.trig_out_en};
assign n_alt_dat = {{(EXP_W-1){1'b0}}, trig_sel};

assign n_dat = (n_alt & n_alt_dat) | (~n_alt & exp_n_dat_i);
assign n_dir = n_alt | exp_n_dir_i;  // Alternate pins always outputs

always_ff @(posedge adc_clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    exp_n_o    <= '0;
    exp_n_oe_o <= '0;  // All pins released
    trig_ext_o <= 1'b0;
  end else begin
    exp_n_o    <= n_dat;
    exp_n_oe_o <= n_dir;
    trig_ext_o <= trig_ext;
  end
end

a_trig_out_oe: assert property (@(posedge adc_clk)
  rst_n_i && $past(rst_n_i) && $past(mode_i.trig_out_en) |-> exp_n_oe_o[0])
  else $error("n[0] not enabled as trigger output");

endmodule : exp_pin_mux

/* source/reset_ctrl.sv */
module reset_ctrl import rp_pkg::*; (
  input  logic        adc_clk,
  input  logic        rst_n_i,       // Board reset, async
  input  logic        pll_locked_i,
  output logic        rst_n_o,       // Internal reset
  output unlock_cnt_t unlock_cnt_o
);

logic [RST_STAGES-1:0] sync_q;  // Lock synchronizer

//////////////////////////////////////////////////////////////////////
// Reset synchronizer
//////////////////////////////////////////////////////////////////////

// Cleared at once on lost lock, released after RST_STAGES locked edges
always_ff @(posedge adc_clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    sync_q <= '0;
  end else if (!pll_locked_i) begin
    sync_q <= '0;
  end else begin
    sync_q <= {sync_q[RST_STAGES-2:0], pll_locked_i};
  end
end

assign rst_n_o = sync_q[RST_STAGES-1];  // Last stage

//////////////////////////////////////////////////////////////////////
// Unlock counter
//////////////////////////////////////////////////////////////////////

always_ff @(posedge adc_clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    unlock_cnt_o <= '0;
  end else if (!pll_locked_i && !(&unlock_cnt_o)) begin
    unlock_cnt_o <= unlock_cnt_o + 1'b1;  // Holds at all ones
  end
end

// Release only with board reset high and lock held over the last edges
a_rst_follows_board: assert property (@(posedge adc_clk)
  rst_n_o |-> rst_n_i && $past(rst_n_i && pll_locked_i)
              && $past(rst_n_i && pll_locked_i, RST_STAGES))
  else $error("internal reset released without board reset high and PLL lock");

endmodule : reset_ctrl

/* source/rp_analog_top.sv */
module rp_analog_top import rp_pkg::*; (
  input  logic               adc_clk,
  input  logic               rst_n_i,
  input  logic               pll_locked_i,
  // ADC
  input  logic               digital_loop_i,
  input  raw_pair_t          adc_raw_i,
  output adc_pair_t          adc_o,
  // DAC
  input  smp_pair_t          gen_i,         // ASG samples
  input  smp_pair_t          ctl_i,         // PID samples
  output dac_pair_t          dac_o,
  // Expansion connector and triggers
  input  daisy_mode_t        mode_i,
  input  exp_vec_t           exp_p_i,
  input  exp_vec_t           exp_n_dat_i,
  input  exp_vec_t           exp_n_dir_i,
  input  logic [DAISY_W-1:0] daisy_dat_i,
  input  logic               gen_trig_i,
  input  logic               scope_trig_i,
  output exp_vec_t           exp_n_o,
  output exp_vec_t           exp_n_oe_o,
  output logic               trig_ext_o,
  // Diagnostics
  output unlock_cnt_t        unlock_cnt_o
);

logic      rst_n;  // Internal reset, lock qualified
smp_pair_t loop;   // Clamped sums for loopback

//////////////////////////////////////////////////////////////////////
// Reset
//////////////////////////////////////////////////////////////////////

reset_ctrl i_reset_ctrl (
  .adc_clk      (adc_clk     ),
  .rst_n_i      (rst_n_i     ),
  .pll_locked_i (pll_locked_i),
  .rst_n_o      (rst_n       ),
  .unlock_cnt_o (unlock_cnt_o)
);

//////////////////////////////////////////////////////////////////////
// Analog paths
//////////////////////////////////////////////////////////////////////

adc_frontend i_adc_frontend (
  .adc_clk        (adc_clk       ),
  .rst_n_i        (rst_n         ),
  .digital_loop_i (digital_loop_i),
  .adc_raw_i      (adc_raw_i     ),
  .loop_i         (loop          ),  // From the mixer
  .adc_o          (adc_o         )
);

dac_mixer i_dac_mixer (
  .adc_clk (adc_clk),
  .rst_n_i (rst_n  ),
  .gen_i   (gen_i  ),
  .ctl_i   (ctl_i  ),
  .loop_o  (loop   ),
  .dac_o   (dac_o  )
);

//////////////////////////////////////////////////////////////////////
// Expansion pins
//////////////////////////////////////////////////////////////////////

exp_pin_mux i_exp_pin_mux (
  .adc_clk      (adc_clk     ),
  .rst_n_i      (rst_n       ),
  .mode_i       (mode_i      ),
  .exp_p_i      (exp_p_i     ),
  .exp_n_dat_i  (exp_n_dat_i ),
  .exp_n_dir_i  (exp_n_dir_i ),
  .daisy_dat_i  (daisy_dat_i ),
  .gen_trig_i   (gen_trig_i  ),
  .scope_trig_i (scope_trig_i),
  .exp_n_o      (exp_n_o     ),
  .exp_n_oe_o   (exp_n_oe_o  ),
  .trig_ext_o   (trig_ext_o  )
);

endmodule : rp_analog_top

/* source/rp_pkg.sv */
package rp_pkg;

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

localparam int ADC_W      = 16;  // ADC sample
localparam int DAC_W      = 14;  // DAC sample
localparam int SUM_W      = 15;  // Mixer sum, one guard bit
localparam int EXP_W      = 11;  // Expansion pins per row
localparam int DAISY_W    = 16;  // Received daisy word
localparam int CNT_W      = 32;  // Unlock counter
localparam int RST_STAGES = 2;   // Reset synchronizer depth

//////////////////////////////////////////////////////////////////////
// Sample and vector types
//////////////////////////////////////////////////////////////////////

typedef logic        [ADC_W-1:0] adc_raw_t;    // Negative-slope ADC word
typedef logic signed [ADC_W-1:0] adc_smp_t;    // Two's complement ADC sample
typedef logic signed [DAC_W-1:0] dac_smp_t;    // Two's complement DAC sample
typedef logic        [DAC_W-1:0] dac_code_t;   // Negative-slope DAC code
typedef logic        [EXP_W-1:0] exp_vec_t;    // One bit per pin
typedef logic        [CNT_W-1:0] unlock_cnt_t; // Cycles without PLL lock

// Channel pairs, channel a in the low half
typedef struct packed {
  adc_raw_t b;
  adc_raw_t a;
} raw_pair_t;

typedef struct packed {
  adc_smp_t b;
  adc_smp_t a;
} adc_pair_t;

// Generator, controller and loopback samples
typedef struct packed {
  dac_smp_t b;
  dac_smp_t a;
} smp_pair_t;

typedef struct packed {
  dac_code_t b;
  dac_code_t a;
} dac_pair_t;

// Daisy mode, sync_mode lands on bit 0
typedef struct packed {
  logic trig_src_gen;  // 1 generator trigger, 0 scope trigger
  logic trig_out_en;   // n[0] drives the trigger out
  logic sync_mode;     // Daisy trigger masks external trigger
} daisy_mode_t;

endpackage : rp_pkg

/* testbench/tb_rp_analog_top.sv */
module tb_rp_analog_top import rp_pkg::*; ();

timeunit 1ns;
timeprecision 1ps;

logic adc_clk, rst_n_i, pll_locked_i, digital_loop_i;
logic gen_trig_i, scope_trig_i, trig_ext_o;
raw_pair_t          adc_raw_i;
adc_pair_t          adc_o;
smp_pair_t          gen_i, ctl_i;
dac_pair_t          dac_o;
daisy_mode_t        mode_i;
exp_vec_t           exp_p_i, exp_n_dat_i, exp_n_dir_i, exp_n_o, exp_n_oe_o;
logic [DAISY_W-1:0] daisy_dat_i;
unlock_cnt_t        unlock_cnt_o;
int unsigned        cycles = 0;  // Timeout counter

rp_analog_top i_dut (.*);

tb_rp_checker i_checker (
  .*,
  .dut_adc_i        (adc_o       ),
  .dut_dac_i        (dac_o       ),
  .dut_exp_n_i      (exp_n_o     ),
  .dut_exp_n_oe_i   (exp_n_oe_o  ),
  .dut_trig_ext_i   (trig_ext_o  ),
  .dut_unlock_cnt_i (unlock_cnt_o)
);

//////////////////////////////////////////////////////////////////////
// Clock and timeout
//////////////////////////////////////////////////////////////////////

initial begin
  adc_clk = 1'b0;
  forever #20 adc_clk = ~adc_clk;  // 40 ns period
end

// About 600 cycles of tests, limit well above
always @(posedge adc_clk) begin
  cycles++;
  if (cycles == 1000) begin
    $display("Timeout: the run did not finish within 1000 clock cycles");
    $display("tests failed");
    $finish;
  end
end

//////////////////////////////////////////////////////////////////////
// Stimulus
//////////////////////////////////////////////////////////////////////

// New random inputs on the falling edge
task automatic drive_random(input logic loop_en);
  logic [31:0] r;
  @(negedge adc_clk);
  digital_loop_i = loop_en;
  adc_raw_i      = $urandom;
  r              = $urandom;
  gen_i          = r[27:0];
  r              = $urandom;
  ctl_i          = r[27:0];
  r              = $urandom;
  exp_p_i        = r[10:0];
  exp_n_dat_i    = r[21:11];
  mode_i         = r[24:22];
  gen_trig_i     = r[25];
  scope_trig_i   = r[26];
  r              = $urandom;
  exp_n_dir_i    = r[10:0];
  daisy_dat_i    = r[31] ? r[26:11] : '0;  // Half empty so sync mode lets p[0] through
endtask

// Same sample pair on both channels
task automatic force_sum(input dac_smp_t g, input dac_smp_t c, input logic loop_en);
  drive_random(loop_en);
  gen_i = {g, g};
  ctl_i = {c, c};
endtask

// PLL unlocked for k edges
task automatic drop_lock(input int k);
  @(negedge adc_clk);
  pll_locked_i = 1'b0;
  repeat (k) @(negedge adc_clk);
  pll_locked_i = 1'b1;
endtask

initial begin
  dac_smp_t smax;
  dac_smp_t smin;
  int       total;
  smax = 14'sh1fff;
  smin = 14'sh2000;
  void'($urandom(86138));
  rst_n_i        = 1'b0;
  pll_locked_i   = 1'b1;
  digital_loop_i = 1'b0;
  adc_raw_i      = '0;
  gen_i          = '0;
  ctl_i          = '0;
  mode_i         = '0;
  exp_p_i        = '0;
  exp_n_dat_i    = '0;
  exp_n_dir_i    = '0;
  daisy_dat_i    = '0;
  gen_trig_i     = 1'b0;
  scope_trig_i   = 1'b0;
  repeat (2) @(negedge adc_clk);
  rst_n_i = 1'b1;
  repeat (150) drive_random(1'b0);  // ADC conversion, triggers
  repeat (10) begin                 // Saturation corners
    force_sum(smax, smax, 1'b0);
    force_sum(smin, smin, 1'b0);
    force_sum(smax, smin, 1'b0);
    drive_random(1'b0);
  end
  repeat (150) drive_random(1'b1);  // Loopback
  repeat (5) begin
    force_sum(smax, smax, 1'b1);
    force_sum(smin, smin, 1'b1);
  end
  drop_lock(1);
  repeat (10) drive_random(1'b0);
  drop_lock(3);
  repeat (10) drive_random(1'b0);
  drop_lock(7);
  repeat (10) drive_random(1'b1);
  @(negedge adc_clk);
  rst_n_i = 1'b0;                   // Board reset mid-run
  repeat (2) @(negedge adc_clk);
  rst_n_i = 1'b1;
  repeat (20) drive_random(1'b0);
  repeat (75) begin                 // Loopback toggling each cycle
    drive_random(1'b0);
    drive_random(1'b1);
  end
  repeat (2) @(negedge adc_clk);
  total = i_checker.adc_err + i_checker.dac_err + i_checker.n_err
        + i_checker.oe_err + i_checker.trig_err + i_checker.cnt_err;
  $display("Errors: adc_o %0d dac_o %0d exp_n_o %0d exp_n_oe_o %0d trig_ext_o %0d unlock_cnt_o %0d",
           i_checker.adc_err, i_checker.dac_err, i_checker.n_err,
           i_checker.oe_err, i_checker.trig_err, i_checker.cnt_err);
  if (total == 0) begin
    $display("all tests passed");
  end else begin
    $display("tests failed");
  end
  $finish;
end

endmodule : tb_rp_analog_top

/* testbench/tb_rp_checker.sv */
module tb_rp_checker import rp_pkg::*; (
  input logic               adc_clk,
  input logic               rst_n_i,
  input logic               pll_locked_i,
  input logic               digital_loop_i,
  input raw_pair_t          adc_raw_i,
  input smp_pair_t          gen_i,
  input smp_pair_t          ctl_i,
  input daisy_mode_t        mode_i,
  input exp_vec_t           exp_p_i,
  input exp_vec_t           exp_n_dat_i,
  input exp_vec_t           exp_n_dir_i,
  input logic [DAISY_W-1:0] daisy_dat_i,
  input logic               gen_trig_i,
  input logic               scope_trig_i,
  input adc_pair_t          dut_adc_i,        // Observed DUT outputs
  input dac_pair_t          dut_dac_i,
  input exp_vec_t           dut_exp_n_i,
  input exp_vec_t           dut_exp_n_oe_i,
  input logic               dut_trig_ext_i,
  input unlock_cnt_t        dut_unlock_cnt_i
);

timeunit 1ns;
timeprecision 1ps;

int adc_err = 0, dac_err = 0, n_err = 0;
int oe_err = 0, trig_err = 0, cnt_err = 0;

logic        armed = 1'b0;  // Skips the first edge
logic [1:0]  ok_cnt;        // Locked edges since reset, stops at 2
logic        live;          // Model internal reset released
unlock_cnt_t cnt_ref;
adc_pair_t   adc_ref;       // Expected outputs for the next edge
dac_pair_t   dac_ref;
exp_vec_t    n_ref;
exp_vec_t    oe_ref;
logic        trig_ref;

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

// Sum clamped to the signed DAC range
function automatic dac_smp_t clamp(input dac_smp_t g, input dac_smp_t c);
  int lim;
  int s;
  lim = 1 << (DAC_W - 1);
  s   = int'(g) + int'(c);
  if (s > lim - 1) begin
    s = lim - 1;
  end else if (s < -lim) begin
    s = -lim;
  end
  return dac_smp_t'(s);
endfunction

task automatic flag_error(inout int cnt, input string name,
                          input logic [31:0] exp_v, input logic [31:0] act_v);
  cnt++;
  $display("ERROR at %0t ns: %s expected %0h actual %0h", $time, name, exp_v, act_v);
endtask

assign live = pll_locked_i && (ok_cnt == 2'd2);  // Lost lock zeroes from this edge

always @(posedge adc_clk) armed <= 1'b1;

always_ff @(posedge adc_clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    ok_cnt   <= '0;
    cnt_ref  <= '0;
    adc_ref  <= '0;
    dac_ref  <= '0;
    n_ref    <= '0;
    oe_ref   <= '0;
    trig_ref <= 1'b0;
  end else begin
    ok_cnt <= !pll_locked_i ? 2'd0 : (ok_cnt == 2'd2 ? ok_cnt : ok_cnt + 2'd1);
    if (!pll_locked_i && cnt_ref != '1) begin
      cnt_ref <= cnt_ref + 1'b1;
    end
    // Loopback zero extended, otherwise low 15 bits flipped
    adc_ref.a <= digital_loop_i ? {2'b00, clamp(gen_i.a, ctl_i.a)} : adc_raw_i.a ^ 16'h7fff;
    adc_ref.b <= digital_loop_i ? {2'b00, clamp(gen_i.b, ctl_i.b)} : adc_raw_i.b ^ 16'h7fff;
    dac_ref.a <= clamp(gen_i.a, ctl_i.a) ^ 14'h1fff;  // Negative slope
    dac_ref.b <= clamp(gen_i.b, ctl_i.b) ^ 14'h1fff;
    trig_ref  <= exp_p_i[0] && !(mode_i.sync_mode && daisy_dat_i != '0);
    n_ref     <= exp_n_dat_i;
    oe_ref    <= exp_n_dir_i;
    if (mode_i.trig_out_en) begin
      n_ref[0]  <= mode_i.trig_src_gen ? gen_trig_i : scope_trig_i;
      oe_ref[0] <= 1'b1;
    end
    if (!live) begin  // Held in internal reset
      adc_ref  <= '0;
      dac_ref  <= '0;
      n_ref    <= '0;
      oe_ref   <= '0;
      trig_ref <= 1'b0;
    end
  end
end

//////////////////////////////////////////////////////////////////////
// Output checks
//////////////////////////////////////////////////////////////////////

a_adc: assert property (@(posedge adc_clk) armed |-> dut_adc_i == adc_ref)
  else flag_error(adc_err, "adc_o", $sampled(adc_ref), $sampled(dut_adc_i));
a_dac: assert property (@(posedge adc_clk) armed |-> dut_dac_i == dac_ref)
  else flag_error(dac_err, "dac_o", $sampled(dac_ref), $sampled(dut_dac_i));
a_n: assert property (@(posedge adc_clk) armed |-> dut_exp_n_i == n_ref)
  else flag_error(n_err, "exp_n_o", $sampled(n_ref), $sampled(dut_exp_n_i));
a_oe: assert property (@(posedge adc_clk) armed |-> dut_exp_n_oe_i == oe_ref)
  else flag_error(oe_err, "exp_n_oe_o", $sampled(oe_ref), $sampled(dut_exp_n_oe_i));
a_trig: assert property (@(posedge adc_clk) armed |-> dut_trig_ext_i == trig_ref)
  else flag_error(trig_err, "trig_ext_o", $sampled(trig_ref), $sampled(dut_trig_ext_i));
a_cnt: assert property (@(posedge adc_clk) armed |-> dut_unlock_cnt_i == cnt_ref)
  else flag_error(cnt_err, "unlock_cnt_o", $sampled(cnt_ref), $sampled(dut_unlock_cnt_i));

endmodule : tb_rp_checker
